// ==== logic/datapathPkg.sv ====
package datapathPkg;

    // Machine word and register file geometry
    localparam int DataWidth = 32;
    localparam int RegCount = 16;
    localparam int RegIndexWidth = 4;

    // Shift and rotate distance comes from the low bus bits
    localparam int ShiftWidth = $clog2(DataWidth);

    // Operation captured by a Z load
    typedef enum logic [3:0] {
        add,
        sub,
        neg,
        mul,
        andOp,
        orOp,
        notOp,
        shl,
        shr,
        shra,
        rol,
        ror
    } aluOpT;

    // Who drives the internal bus this cycle
    typedef enum logic [2:0] {
        srcNone,
        srcRegister,
        srcMdr,
        srcZLow,
        srcZHigh,
        srcImmediate
    } busSrcT;

endpackage

// ==== logic/registerFile.sv ====
`timescale 1ns/10ps
module registerFile (
    input  logic                                 Clock,
    input  logic                                 rst,
    input  logic [datapathPkg::RegIndexWidth-1:0] regIndex,
    input  logic                                 regWrite,
    input  logic [datapathPkg::DataWidth-1:0]     busIn,
    output logic [datapathPkg::DataWidth-1:0]     readData
);
    import datapathPkg::*;

    logic [DataWidth-1:0] regs [RegCount];

    // One index per cycle, shared by read and write
    always_ff @(posedge Clock) begin
        if (rst) begin
            for (int i = 0; i < RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite) begin
            regs[regIndex] <= busIn;
        end
    end

    // Combinational read of the selected register
    assign readData = regs[regIndex];

endmodule

// ==== logic/busSelect.sv ====
`timescale 1ns/10ps
module busSelect (
    input  logic                               Clock,
    input  logic                               rst,
    input  datapathPkg::busSrcT                busSource,
    input  logic [datapathPkg::DataWidth-1:0]   readData,
    input  logic [datapathPkg::DataWidth-1:0]   mdrValue,
    input  logic [2*datapathPkg::DataWidth-1:0] zValue,
    input  logic [datapathPkg::DataWidth-1:0]   immediate,
    input  logic                               yLoad,
    output logic [datapathPkg::DataWidth-1:0]   busValue,
    output logic [datapathPkg::DataWidth-1:0]   yValue
);
    import datapathPkg::*;

    // Single bus, one driver per cycle
    always_comb begin
        case (busSource)
            srcNone: begin
                busValue = '0;
            end
            srcRegister: begin
                busValue = readData;
            end
            srcMdr: begin
                busValue = mdrValue;
            end
            srcZLow: begin
                busValue = zValue[DataWidth-1:0];
            end
            srcZHigh: begin
                busValue = zValue[2*DataWidth-1:DataWidth];
            end
            srcImmediate: begin
                busValue = immediate;
            end
            default: begin
                busValue = '0;
            end
        endcase
    end

    // Y holds the first ALU operand
    always_ff @(posedge Clock) begin
        if (rst) begin
            yValue <= '0;
        end else if (yLoad) begin
            yValue <= busValue;
        end
    end

endmodule

// ==== logic/arithmeticUnit.sv ====
`timescale 1ns/10ps
module arithmeticUnit (
    input  datapathPkg::aluOpT                 aluOp,
    input  logic [datapathPkg::DataWidth-1:0]   yValue,
    input  logic [datapathPkg::DataWidth-1:0]   busValue,
    output logic [2*datapathPkg::DataWidth-1:0] arithResult
);
    import datapathPkg::*;

    logic [DataWidth-1:0]          sum;
    logic [DataWidth-1:0]          difference;
    logic [DataWidth-1:0]          negated;
    logic signed [2*DataWidth-1:0] product;

    assign sum = yValue + busValue;
    assign difference = yValue - busValue;
    assign negated = '0 - busValue;

    // Both operands sign extended to the full product width
    assign product = $signed(yValue) * $signed(busValue);

    always_comb begin
        case (aluOp)
            add: begin
                arithResult = {{DataWidth{1'b0}}, sum};
            end
            sub: begin
                arithResult = {{DataWidth{1'b0}}, difference};
            end
            neg: begin
                arithResult = {{DataWidth{1'b0}}, negated};
            end
            mul: begin
                arithResult = product;
            end
            default: begin
                // Logic class, result unused
                arithResult = '0;
            end
        endcase
    end

endmodule

// ==== logic/logicUnit.sv ====
`timescale 1ns/10ps
module logicUnit (
    input  datapathPkg::aluOpT               aluOp,
    input  logic [datapathPkg::DataWidth-1:0] yValue,
    input  logic [datapathPkg::DataWidth-1:0] busValue,
    output logic [datapathPkg::DataWidth-1:0] logicResult
);
    import datapathPkg::*;

    logic [ShiftWidth-1:0]  shiftAmount;
    logic [2*DataWidth-1:0] rolWide;
    logic [2*DataWidth-1:0] rorWide;

    // Distance taken from the low bus bits only
    assign shiftAmount = busValue[ShiftWidth-1:0];

    // Rotates via a doubled copy of Y
    assign rolWide = {yValue, yValue} << shiftAmount;
    assign rorWide = {yValue, yValue} >> shiftAmount;

    always_comb begin
        case (aluOp)
            andOp: begin
                logicResult = yValue & busValue;
            end
            orOp: begin
                logicResult = yValue | busValue;
            end
            notOp: begin
                logicResult = ~busValue;
            end
            shl: begin
                logicResult = yValue << shiftAmount;
            end
            shr: begin
                logicResult = yValue >> shiftAmount;
            end
            shra: begin
                // Sign bit fills from the left
                logicResult = $signed(yValue) >>> shiftAmount;
            end
            rol: begin
                logicResult = rolWide[2*DataWidth-1:DataWidth];
            end
            ror: begin
                logicResult = rorWide[DataWidth-1:0];
            end
            default: begin
                logicResult = '0;
            end
        endcase
    end

endmodule

// ==== logic/resultRegister.sv ====
`timescale 1ns/10ps
module resultRegister (
    input  logic                               Clock,
    input  logic                               rst,
    input  datapathPkg::aluOpT                 aluOp,
    input  logic                               zLoad,
    input  logic [2*datapathPkg::DataWidth-1:0] arithResult,
    input  logic [datapathPkg::DataWidth-1:0]   logicResult,
    output logic [2*datapathPkg::DataWidth-1:0] zValue
);
    import datapathPkg::*;

    logic arithClass;

    // Operation class decides which unit feeds Z
    always_comb begin
        case (aluOp)
            add, sub, neg, mul: begin
                arithClass = 1'b1;
            end
            default: begin
                arithClass = 1'b0;
            end
        endcase
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            zValue <= '0;
        end else if (zLoad) begin
            if (arithClass) begin
                zValue <= arithResult;
            end else begin
                // Logic results land in the low half
                zValue <= {{DataWidth{1'b0}}, logicResult};
            end
        end
    end

endmodule

// ==== logic/memoryInterface.sv ====
`timescale 1ns/10ps
module memoryInterface (
    input  logic                             Clock,
    input  logic                             rst,
    input  logic [datapathPkg::DataWidth-1:0] busValue,
    input  logic                             marLoad,
    input  logic                             mdrLoad,
    input  logic                             memRead,
    input  logic                             memWrite,
    output logic [datapathPkg::DataWidth-1:0] mdrValue,
    output logic                             memBusy,
    output logic                             memDone,
    output logic                             wbCyc,
    output logic                             wbStb,
    output logic                             wbWe,
    output logic [datapathPkg::DataWidth-1:0] wbAdr,
    output logic [datapathPkg::DataWidth-1:0] wbDatOut,
    input  logic [datapathPkg::DataWidth-1:0] wbDatIn,
    input  logic                             wbAck
);
    import datapathPkg::*;

    typedef enum logic {
        stIdle,
        stAccess
    } memStateT;

    memStateT             state;
    logic [DataWidth-1:0] mar;
    logic [DataWidth-1:0] mdr;
    logic                 ackSeen;

    assign ackSeen = (state == stAccess) && wbAck;

    // Bus cycle control, strobes while busy are dropped
    always_ff @(posedge Clock) begin
        if (rst) begin
            state <= stIdle;
            wbWe <= 1'b0;
            memDone <= 1'b0;
        end else begin
            memDone <= ackSeen;
            if (state == stIdle && (memRead || memWrite)) begin
                state <= stAccess;
                wbWe <= memWrite;
            end else if (ackSeen) begin
                state <= stIdle;
                wbWe <= 1'b0;
            end
        end
    end

    // MAR and MDR, a read return has priority over a bus load
    always_ff @(posedge Clock) begin
        if (rst) begin
            mar <= '0;
            mdr <= '0;
        end else begin
            if (marLoad) begin
                mar <= busValue;
            end
            if (ackSeen && !wbWe) begin
                mdr <= wbDatIn;
            end else if (mdrLoad) begin
                mdr <= busValue;
            end
        end
    end

    assign wbCyc = (state == stAccess);
    assign wbStb = (state == stAccess);
    assign memBusy = (state == stAccess);
    assign wbAdr = mar;
    assign wbDatOut = mdr;
    assign mdrValue = mdr;

endmodule

// ==== logic/busDatapath.sv ====
`timescale 1ns/10ps
module busDatapath (
    input  logic                                 Clock,
    input  logic                                 rst,
    input  datapathPkg::busSrcT                  busSource,
    input  logic [datapathPkg::RegIndexWidth-1:0] regIndex,
    input  logic [datapathPkg::DataWidth-1:0]     immediate,
    input  logic                                 regWrite,
    input  logic                                 yLoad,
    input  logic                                 zLoad,
    input  logic                                 marLoad,
    input  logic                                 mdrLoad,
    input  datapathPkg::aluOpT                   aluOp,
    input  logic                                 memRead,
    input  logic                                 memWrite,
    output logic [datapathPkg::DataWidth-1:0]     busValue,
    output logic                                 memBusy,
    output logic                                 memDone,
    output logic                                 wbCyc,
    output logic                                 wbStb,
    output logic                                 wbWe,
    output logic [datapathPkg::DataWidth-1:0]     wbAdr,
    output logic [datapathPkg::DataWidth-1:0]     wbDatOut,
    input  logic [datapathPkg::DataWidth-1:0]     wbDatIn,
    input  logic                                 wbAck
);
    import datapathPkg::*;

    logic [DataWidth-1:0]   readData;
    logic [DataWidth-1:0]   mdrValue;
    logic [DataWidth-1:0]   yValue;
    logic [2*DataWidth-1:0] zValue;
    logic [2*DataWidth-1:0] arithResult;
    logic [DataWidth-1:0]   logicResult;

    registerFile i_registerFile (
        .Clock    (Clock),
        .rst      (rst),
        .regIndex (regIndex),
        .regWrite (regWrite),
        .busIn    (busValue),
        .readData (readData)
    );

    busSelect i_busSelect (
        .Clock     (Clock),
        .rst       (rst),
        .busSource (busSource),
        .readData  (readData),
        .mdrValue  (mdrValue),
        .zValue    (zValue),
        .immediate (immediate),
        .yLoad     (yLoad),
        .busValue  (busValue),
        .yValue    (yValue)
    );

    // Both units see Y and the bus every cycle
    arithmeticUnit i_arithmeticUnit (
        .aluOp       (aluOp),
        .yValue      (yValue),
        .busValue    (busValue),
        .arithResult (arithResult)
    );

    logicUnit i_logicUnit (
        .aluOp       (aluOp),
        .yValue      (yValue),
        .busValue    (busValue),
        .logicResult (logicResult)
    );

    resultRegister i_resultRegister (
        .Clock       (Clock),
        .rst         (rst),
        .aluOp       (aluOp),
        .zLoad       (zLoad),
        .arithResult (arithResult),
        .logicResult (logicResult),
        .zValue      (zValue)
    );

    memoryInterface i_memoryInterface (
        .Clock    (Clock),
        .rst      (rst),
        .busValue (busValue),
        .marLoad  (marLoad),
        .mdrLoad  (mdrLoad),
        .memRead  (memRead),
        .memWrite (memWrite),
        .mdrValue (mdrValue),
        .memBusy  (memBusy),
        .memDone  (memDone),
        .wbCyc    (wbCyc),
        .wbStb    (wbStb),
        .wbWe     (wbWe),
        .wbAdr    (wbAdr),
        .wbDatOut (wbDatOut),
        .wbDatIn  (wbDatIn),
        .wbAck    (wbAck)
    );

endmodule

// ==== dv/busDatapath_checker.sv ====
`timescale 1ns/10ps
module busDatapath_checker (
    input logic                             Clock,
    input logic                             rst,
    input logic                             wbCyc,
    input logic                             wbStb,
    input logic                             wbWe,
    input logic                             wbAck,
    input logic [datapathPkg::DataWidth-1:0] wbAdr,
    input logic                             memBusy,
    input logic                             memDone,
    input logic                             memRead,
    input logic                             memWrite
);

    stbWithinCyc: assert property (@(posedge Clock) disable iff (rst) wbStb |-> wbCyc)
        else $error("wbStb high without wbCyc");

    // Address held until the slave answers
    cycleHeld: assert property (@(posedge Clock) disable iff (rst)
        (wbCyc && !wbAck) |=> (wbCyc && $stable(wbAdr)))
        else $error("Wishbone cycle or address changed before wbAck");

    doneOneCycle: assert property (@(posedge Clock) disable iff (rst) memDone |=> !memDone)
        else $error("memDone high for more than one cycle");

    noStrobeWhileBusy: assert property (@(posedge Clock) disable iff (rst)
        memBusy |-> !(memRead || memWrite))
        else $error("Memory strobe while memBusy is high");

    resetIdle: assert property (@(posedge Clock)
        rst |=> (!wbCyc && !wbStb && !wbWe && !memBusy && !memDone))
        else $error("Control outputs not low after reset");

endmodule

bind busDatapath busDatapath_checker i_checker (
    .Clock    (Clock),
    .rst      (rst),
    .wbCyc    (wbCyc),
    .wbStb    (wbStb),
    .wbWe     (wbWe),
    .wbAck    (wbAck),
    .wbAdr    (wbAdr),
    .memBusy  (memBusy),
    .memDone  (memDone),
    .memRead  (memRead),
    .memWrite (memWrite)
);

// ==== dv/busDatapathTb.sv ====
`timescale 1ns/10ps
module busDatapathTb;
    import datapathPkg::*;

    // About twice the length of the full test run
    localparam int CycleLimit = 4000;
    localparam int AluRounds = 16;
    localparam int MulRounds = 32;
    localparam int MemRounds = 32;
    localparam int MemWords = 256;

    // Load strobe masks in the order regWrite, yLoad, zLoad, marLoad, mdrLoad
    localparam logic [4:0] LoadReg = 5'b10000;
    localparam logic [4:0] LoadY = 5'b01000;
    localparam logic [4:0] LoadZ = 5'b00100;
    localparam logic [4:0] LoadMar = 5'b00010;
    localparam logic [4:0] LoadMdr = 5'b00001;

    logic                     Clock;
    logic                     rst;
    busSrcT                   busSource;
    logic [RegIndexWidth-1:0] regIndex;
    logic [DataWidth-1:0]     immediate;
    logic                     regWrite;
    logic                     yLoad;
    logic                     zLoad;
    logic                     marLoad;
    logic                     mdrLoad;
    aluOpT                    aluOp;
    logic                     memRead;
    logic                     memWrite;
    logic [DataWidth-1:0]     busValue;
    logic                     memBusy;
    logic                     memDone;
    logic                     wbCyc;
    logic                     wbStb;
    logic                     wbWe;
    logic [DataWidth-1:0]     wbAdr;
    logic [DataWidth-1:0]     wbDatOut;
    logic [DataWidth-1:0]     wbDatIn;
    logic                     wbAck;

    logic [DataWidth-1:0] mem [MemWords];
    integer               seed = 32'h8953;
    int                   cycleCount;
    logic                 checkPending;
    logic [DataWidth-1:0] expValue;
    string                expName;
    aluOpT                testOps [11] = '{add, sub, neg, andOp, orOp, notOp,
                                           shl, shr, shra, rol, ror};

    busDatapath i_dut (
        .Clock     (Clock),
        .rst       (rst),
        .busSource (busSource),
        .regIndex  (regIndex),
        .immediate (immediate),
        .regWrite  (regWrite),
        .yLoad     (yLoad),
        .zLoad     (zLoad),
        .marLoad   (marLoad),
        .mdrLoad   (mdrLoad),
        .aluOp     (aluOp),
        .memRead   (memRead),
        .memWrite  (memWrite),
        .busValue  (busValue),
        .memBusy   (memBusy),
        .memDone   (memDone),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbWe      (wbWe),
        .wbAdr     (wbAdr),
        .wbDatOut  (wbDatOut),
        .wbDatIn   (wbDatIn),
        .wbAck     (wbAck)
    );

    initial begin
        Clock = 1'b0;
        forever #2 Clock = ~Clock;
    end

    // Expected Z for one operation on Y and the bus
    function automatic logic [2*DataWidth-1:0] refAlu(input aluOpT op,
            input logic [DataWidth-1:0] y, input logic [DataWidth-1:0] b);
        int                     signedY;
        int                     signedB;
        logic [4:0]             amount;
        logic [2*DataWidth-1:0] extended;
        logic [2*DataWidth-1:0] result;
        signedY = y;
        signedB = b;
        amount = b[4:0];
        extended = {{DataWidth{y[DataWidth-1]}}, y};
        result = '0;
        case (op)
            add: result[DataWidth-1:0] = y + b;
            sub: result[DataWidth-1:0] = y - b;
            neg: result[DataWidth-1:0] = 0 - b;
            mul: result = longint'(signedY) * longint'(signedB);
            andOp: result[DataWidth-1:0] = y & b;
            orOp: result[DataWidth-1:0] = y | b;
            notOp: result[DataWidth-1:0] = ~b;
            shl: result[DataWidth-1:0] = y << amount;
            shr: result[DataWidth-1:0] = y >> amount;
            shra: begin
                extended = extended >> amount;
                result[DataWidth-1:0] = extended[DataWidth-1:0];
            end
            rol: result[DataWidth-1:0] = (y << amount) | (y >> (DataWidth - amount));
            ror: result[DataWidth-1:0] = (y >> amount) | (y << (DataWidth - amount));
            default: result = '0;
        endcase
        return result;
    endfunction

    // Initial memory contents distinct per word
    function automatic logic [DataWidth-1:0] fillWord(input logic [7:0] addr);
        return {~addr, addr ^ 8'h5A, addr + 8'h11, addr};
    endfunction

    task automatic reportFailure();
        $display("RESULT: FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic idleInputs();
        busSource = srcNone;
        regIndex = '0;
        immediate = '0;
        {regWrite, yLoad, zLoad, marLoad, mdrLoad} = '0;
        aluOp = add;
        memRead = 1'b0;
        memWrite = 1'b0;
    endtask

    // One micro-step entered and left 0.5 ns after a rising edge
    task automatic driveStep(input busSrcT src, input logic [RegIndexWidth-1:0] idx,
            input logic [DataWidth-1:0] imm, input logic [4:0] loads, input aluOpT op);
        busSource = src;
        regIndex = idx;
        immediate = imm;
        {regWrite, yLoad, zLoad, marLoad, mdrLoad} = loads;
        aluOp = op;
        @(posedge Clock);
        #0.5;
        idleInputs();
    endtask

    // Put a source on the bus and hand the expected word to the comparing process
    task automatic readBus(input busSrcT src, input logic [RegIndexWidth-1:0] idx,
            input logic [DataWidth-1:0] expected, input string name);
        busSource = src;
        regIndex = idx;
        expValue = expected;
        expName = name;
        checkPending = 1'b1;
        @(posedge Clock);
        #0.5;
        idleInputs();
    endtask

    task automatic memAccess(input logic write);
        memRead = !write;
        memWrite = write;
        @(posedge Clock);
        #0.5;
        memRead = 1'b0;
        memWrite = 1'b0;
        // Busy from the first access cycle until the acknowledge edge
        assert (memBusy === 1'b1) else begin
            $display("Fail memBusy: expected 1, got %h", memBusy);
            reportFailure();
        end
        while (!memDone) begin
            @(posedge Clock);
            #0.5;
        end
        assert (memBusy === 1'b0) else begin
            $display("Fail memBusy with memDone: expected 0, got %h", memBusy);
            reportFailure();
        end
    endtask

    task automatic runAluCase(input aluOpT op, input logic [RegIndexWidth-1:0] idxA,
            input logic [DataWidth-1:0] opA, input logic [DataWidth-1:0] opB);
        logic [RegIndexWidth-1:0] idxB;
        logic [2*DataWidth-1:0]   expected;
        idxB = idxA + 1'b1;
        driveStep(srcImmediate, idxA, opA, LoadReg, add);
        driveStep(srcImmediate, idxB, opB, LoadReg, add);
        driveStep(srcRegister, idxA, '0, LoadY, add);
        driveStep(srcRegister, idxB, '0, LoadZ, op);
        expected = refAlu(op, opA, opB);
        readBus(srcZLow, '0, expected[DataWidth-1:0], $sformatf("zLow after %s", op.name()));
        readBus(srcZHigh, '0, expected[2*DataWidth-1:DataWidth],
                $sformatf("zHigh after %s", op.name()));
    endtask

    // Comparing process samples the bus mid-cycle
    initial begin
        forever begin
            @(negedge Clock);
            if (checkPending) begin
                assert (busValue === expValue) else begin
                    $display("Fail busValue (%s): expected %h, got %h",
                             expName, expValue, busValue);
                    reportFailure();
                end
                checkPending = 1'b0;
            end
        end
    end

    // Wishbone slave with 0 to 3 wait cycles
    initial begin
        int   ackDelay;
        logic accessActive;
        wbAck = 1'b0;
        wbDatIn = '0;
        ackDelay = 0;
        accessActive = 1'b0;
        for (int a = 0; a < MemWords; a++) begin
            mem[a] = fillWord(a[7:0]);
        end
        forever begin
            @(posedge Clock);
            #0.5;
            if (wbAck) begin
                wbAck = 1'b0;
                accessActive = 1'b0;
            end else if (wbCyc && wbStb) begin
                if (!accessActive) begin
                    accessActive = 1'b1;
                    ackDelay = {$random(seed)} % 4;
                end
                if (ackDelay == 0) begin
                    if (wbWe) begin
                        mem[wbAdr[7:0]] = wbDatOut;
                    end else begin
                        wbDatIn = mem[wbAdr[7:0]];
                    end
                    wbAck = 1'b1;
                end else begin
                    ackDelay = ackDelay - 1;
                end
            end
        end
    end

    initial begin
        cycleCount = 0;
        forever begin
            @(posedge Clock);
            cycleCount++;
            if (cycleCount >= CycleLimit) begin
                $display("Timeout: the tests did not finish within %0d cycles", CycleLimit);
                reportFailure();
            end
        end
    end

    initial begin
        logic [DataWidth-1:0] addr;
        logic [DataWidth-1:0] value;
        rst = 1'b1;
        checkPending = 1'b0;
        idleInputs();
        repeat (4) @(posedge Clock);
        #0.5;
        rst = 1'b0;

        // Reset state
        assert (!wbCyc && !wbStb && !wbWe && !memBusy && !memDone) else begin
            $display("Wishbone or memory status outputs are active after reset");
            reportFailure();
        end
        for (int i = 0; i < RegCount; i++) begin
            readBus(srcRegister, RegIndexWidth'(i), '0, $sformatf("R%0d after reset", i));
        end
        readBus(srcZLow, '0, '0, "zLow after reset");
        readBus(srcZHigh, '0, '0, "zHigh after reset");
        readBus(srcMdr, '0, '0, "MDR after reset");

        // Register load through memory
        addr = $random(seed) & 32'hFF;
        driveStep(srcImmediate, '0, addr, LoadMar, add);
        memAccess(1'b0);
        driveStep(srcMdr, 4'd7, '0, LoadReg, add);
        readBus(srcRegister, 4'd7, fillWord(addr[7:0]), "R7 after memory load");

        for (int round = 0; round < AluRounds; round++) begin
            for (int k = 0; k < 11; k++) begin
                runAluCase(testOps[k], RegIndexWidth'(round), $random(seed), $random(seed));
            end
        end

        for (int round = 0; round < MulRounds; round++) begin
            runAluCase(mul, RegIndexWidth'(round + 3), $random(seed), $random(seed));
        end

        // Write to memory, clear MDR, read back
        for (int round = 0; round < MemRounds; round++) begin
            value = $random(seed);
            addr = $random(seed) & 32'hFF;
            driveStep(srcImmediate, 4'd3, value, LoadReg, add);
            driveStep(srcRegister, 4'd3, '0, LoadMdr, add);
            driveStep(srcImmediate, '0, addr, LoadMar, add);
            memAccess(1'b1);
            assert (mem[addr[7:0]] === value) else begin
                $display("Fail mem[%h]: expected %h, got %h", addr[7:0], value, mem[addr[7:0]]);
                reportFailure();
            end
            driveStep(srcNone, '0, '0, LoadMdr, add);
            readBus(srcMdr, '0, '0, "MDR cleared before read-back");
            memAccess(1'b0);
            readBus(srcMdr, '0, value, "MDR after read-back");
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== flist.f ====
logic/datapathPkg.sv
logic/registerFile.sv
logic/busSelect.sv
logic/arithmeticUnit.sv
logic/logicUnit.sv
logic/resultRegister.sv
logic/memoryInterface.sv
logic/busDatapath.sv
dv/busDatapath_checker.sv
dv/busDatapathTb.sv

// ==== Bender.yml ====
package:
  name: busDatapath

sources:
  # Design sources in compile order
  - files:
      - logic/datapathPkg.sv
      - logic/registerFile.sv
      - logic/busSelect.sv
      - logic/arithmeticUnit.sv
      - logic/logicUnit.sv
      - logic/resultRegister.sv
      - logic/memoryInterface.sv
      - logic/busDatapath.sv

  # Testbench and bound checker
  - target: simulation
    files:
      - dv/busDatapath_checker.sv
      - dv/busDatapathTb.sv
